// ==== Makefile ====
# Verilator flow for the xcom serial link
TOP   := tb_xcom_link
FLIST := xcom_link.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module xcom_link -f $(FLIST)

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== source/xcom_link.sv ====
// serial command link top, everything on i_ps_clk
// rx channel is chosen by CFG bits from 8 upward, NCH channels
`timescale 1ns/1ps

module xcom_link #(
  parameter  int NCH   = 2,
  localparam int SEL_W = (NCH > 1) ? $clog2(NCH) : 1
) (
  input  logic                         i_ps_clk,
  input  logic                         i_ps_rstn,
  // apb
  input  logic                         i_psel,
  input  logic                         i_penable,
  input  logic                         i_pwrite,
  input  logic [xcom_pkg::APB_AW-1:0]  i_paddr,
  input  logic [xcom_pkg::DW-1:0]      i_pwdata,
  output logic [xcom_pkg::DW-1:0]      o_prdata,
  output logic                         o_pready,
  output logic                         o_pslverr,
  // serial
  input  logic [NCH-1:0]               i_xcom_clk,
  input  logic [NCH-1:0]               i_xcom_data,
  output logic                         o_xcom_clk,
  output logic                         o_xcom_data,
  output logic [3:0]                   o_xcom_id
);

  logic                        tx_start;
  logic                        tx_busy;
  logic [xcom_pkg::HDR_W-1:0]  tx_hdr;
  logic [xcom_pkg::DW-1:0]     tx_data;
  logic [xcom_pkg::TICK_W-1:0] cfg_tick;
  logic [SEL_W-1:0]            rx_sel;
  logic                        rx_valid;
  logic [xcom_pkg::HDR_W-1:0]  rx_hdr;
  logic [xcom_pkg::DW-1:0]     rx_data;

  ////////////////////////////////////////////////////////////////////////////
  // register block
  ////////////////////////////////////////////////////////////////////////////
  xcom_regs #(
    .NCH (NCH)
  ) u_xcom_regs (
    .i_ps_clk   (i_ps_clk),
    .i_ps_rstn  (i_ps_rstn),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .i_tx_busy  (tx_busy),
    .o_tx_start (tx_start),
    .o_tx_hdr   (tx_hdr),
    .o_tx_data  (tx_data),
    .o_cfg_tick (cfg_tick),
    .i_rx_valid (rx_valid),
    .i_rx_hdr   (rx_hdr),
    .i_rx_data  (rx_data),
    .o_rx_sel   (rx_sel)
  );

  // transmit path
  xcom_tx u_xcom_tx (
    .i_ps_clk    (i_ps_clk),
    .i_ps_rstn   (i_ps_rstn),
    .i_start     (tx_start),
    .i_hdr       (tx_hdr),
    .i_data      (tx_data),
    .i_cfg_tick  (cfg_tick),
    .o_busy      (tx_busy),
    .o_xcom_clk  (o_xcom_clk),
    .o_xcom_data (o_xcom_data)
  );

  // receive path
  xcom_rx #(
    .NCH (NCH)
  ) u_xcom_rx (
    .i_ps_clk    (i_ps_clk),
    .i_ps_rstn   (i_ps_rstn),
    .i_cfg_tick  (cfg_tick),
    .i_sel       (rx_sel),
    .i_xcom_clk  (i_xcom_clk),
    .i_xcom_data (i_xcom_data),
    .o_valid     (rx_valid),
    .o_hdr       (rx_hdr),
    .o_data      (rx_data),
    .o_board_id  (o_xcom_id)
  );

endmodule

// ==== source/xcom_pkg.sv ====
// shared widths, APB register map and header length decode for the serial link
// header layout is fixed: [7] sync, [6:5] length code, [4] spare, [3:0] board id
// data payload is limited to 32 bits and is taken from the low end of the word
package xcom_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////
  parameter int APB_AW = 8;
  parameter int DW     = 32;
  parameter int HDR_W  = 8;
  parameter int TICK_W = 3;

  ////////////////////////////////////////////////////////////////////////////
  // register offsets, word aligned
  ////////////////////////////////////////////////////////////////////////////
  parameter logic [APB_AW-1:0] REG_CTRL    = 8'h00;
  parameter logic [APB_AW-1:0] REG_CFG     = 8'h04;
  parameter logic [APB_AW-1:0] REG_TX_HDR  = 8'h08;
  parameter logic [APB_AW-1:0] REG_TX_DATA = 8'h0C;
  parameter logic [APB_AW-1:0] REG_STATUS  = 8'h10;
  parameter logic [APB_AW-1:0] REG_RX_DATA = 8'h14;

  // length code carried in header bits [6:5]
  typedef enum logic [1:0] {
    LEN_NONE = 2'b00,
    LEN_8    = 2'b01,
    LEN_16   = 2'b10,
    LEN_32   = 2'b11
  } len_code_e;

  // number of payload bits that follow the header
  function automatic logic [5:0] data_bits(input len_code_e code);
    case (code)
      LEN_NONE: data_bits = 6'd0;
      LEN_8:    data_bits = 6'd8;
      LEN_16:   data_bits = 6'd16;
      default:  data_bits = 6'd32;
    endcase
  endfunction

endpackage

// ==== source/xcom_regs.sv ====
// APB slave, pready tied high so every transfer is one setup plus one access cycle
// unmapped offsets answer with pslverr and read as zero
// a send while the transmitter is busy is refused, never queued
`timescale 1ns/1ps

module xcom_regs #(
  parameter  int NCH   = 2,
  localparam int SEL_W = (NCH > 1) ? $clog2(NCH) : 1
) (
  input  logic                         i_ps_clk,
  input  logic                         i_ps_rstn,
  // apb
  input  logic                         i_psel,
  input  logic                         i_penable,
  input  logic                         i_pwrite,
  input  logic [xcom_pkg::APB_AW-1:0]  i_paddr,
  input  logic [xcom_pkg::DW-1:0]      i_pwdata,
  output logic [xcom_pkg::DW-1:0]      o_prdata,
  output logic                         o_pready,
  output logic                         o_pslverr,
  // transmitter side
  input  logic                         i_tx_busy,
  output logic                         o_tx_start,
  output logic [xcom_pkg::HDR_W-1:0]   o_tx_hdr,
  output logic [xcom_pkg::DW-1:0]      o_tx_data,
  output logic [xcom_pkg::TICK_W-1:0]  o_cfg_tick,
  // receiver side
  input  logic                         i_rx_valid,
  input  logic [xcom_pkg::HDR_W-1:0]   i_rx_hdr,
  input  logic [xcom_pkg::DW-1:0]      i_rx_data,
  output logic [SEL_W-1:0]             o_rx_sel
);

  logic       acc;
  logic       wr;
  logic       hit_ctrl;
  logic       hit_cfg;
  logic       hit_hdr;
  logic       hit_data;
  logic       hit_stat;
  logic       hit_rxd;
  logic       mapped;
  logic       send_req;
  logic [7:0] frame_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////
  // access phase of an apb transfer
  assign acc = i_psel & i_penable;
  assign wr  = acc & i_pwrite;

  assign hit_ctrl = (i_paddr == xcom_pkg::REG_CTRL);
  assign hit_cfg  = (i_paddr == xcom_pkg::REG_CFG);
  assign hit_hdr  = (i_paddr == xcom_pkg::REG_TX_HDR);
  assign hit_data = (i_paddr == xcom_pkg::REG_TX_DATA);
  assign hit_stat = (i_paddr == xcom_pkg::REG_STATUS);
  assign hit_rxd  = (i_paddr == xcom_pkg::REG_RX_DATA);
  assign mapped   = hit_ctrl | hit_cfg | hit_hdr | hit_data | hit_stat | hit_rxd;

  // send bit is ctrl[0], write only
  assign send_req   = wr & hit_ctrl & i_pwdata[0];
  assign o_tx_start = send_req & ~i_tx_busy;

  // error on unmapped offset or a refused send
  assign o_pslverr = acc & (~mapped | (send_req & i_tx_busy));
  assign o_pready  = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      o_cfg_tick <= '0;
      o_rx_sel   <= '0;
    end else if (wr && hit_cfg) begin
      // tick in [2:0], channel select from bit 8
      o_cfg_tick <= i_pwdata[xcom_pkg::TICK_W-1:0];
      o_rx_sel   <= i_pwdata[8 +: SEL_W];
    end
  end

  // frame in flight is unaffected, tx captured these at start
  always_ff @(posedge i_ps_clk) begin
    if (wr && hit_hdr) begin
      o_tx_hdr <= i_pwdata[xcom_pkg::HDR_W-1:0];
    end
    if (wr && hit_data) begin
      o_tx_data <= i_pwdata;
    end
  end

  // received frames, wraps at 256
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      frame_cnt <= '0;
    end else if (i_rx_valid) begin
      frame_cnt <= frame_cnt + 8'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    o_prdata = '0;
    if (hit_cfg) begin
      o_prdata[xcom_pkg::TICK_W-1:0] = o_cfg_tick;
      o_prdata[8 +: SEL_W]           = o_rx_sel;
    end else if (hit_hdr) begin
      o_prdata[xcom_pkg::HDR_W-1:0] = o_tx_hdr;
    end else if (hit_data) begin
      o_prdata = o_tx_data;
    end else if (hit_stat) begin
      // busy, frame count, last header
      o_prdata[0]     = i_tx_busy;
      o_prdata[15:8]  = frame_cnt;
      o_prdata[23:16] = i_rx_hdr;
    end else if (hit_rxd) begin
      o_prdata = i_rx_data;
    end
  end

  // error response only ever in the access phase
  a_slverr_in_access: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    o_pslverr |-> (i_psel && i_penable));

endmodule

// ==== source/xcom_rx.sv ====
// serial receiver, samples data on the synchronized rising edge of the chosen channel
// a gap of 8*(cfg_tick+2) clocks mid frame drops the partial frame
// received data is right aligned and zero filled above its length
`timescale 1ns/1ps

module xcom_rx #(
  parameter  int NCH   = 2,
  localparam int SEL_W = (NCH > 1) ? $clog2(NCH) : 1
) (
  input  logic                         i_ps_clk,
  input  logic                         i_ps_rstn,
  input  logic [xcom_pkg::TICK_W-1:0]  i_cfg_tick,
  input  logic [SEL_W-1:0]             i_sel,
  input  logic [NCH-1:0]               i_xcom_clk,
  input  logic [NCH-1:0]               i_xcom_data,
  output logic                         o_valid,
  output logic [xcom_pkg::HDR_W-1:0]   o_hdr,
  output logic [xcom_pkg::DW-1:0]      o_data,
  output logic [3:0]                   o_board_id
);

  logic                       clk_raw;
  logic                       dat_raw;
  logic [1:0]                 clk_s;
  logic [1:0]                 dat_s;
  logic                       clk_d;
  logic                       rise;
  logic [xcom_pkg::HDR_W-1:0] hdr_sh;
  logic [xcom_pkg::HDR_W-1:0] hdr_nxt;
  logic [xcom_pkg::DW-1:0]    data_sh;
  logic [xcom_pkg::DW-1:0]    data_nxt;
  logic [5:0]                 bit_cnt;
  logic [5:0]                 tgt;
  logic [5:0]                 n_bits;
  logic [6:0]                 gap_cnt;
  logic [6:0]                 gap_max;

  ////////////////////////////////////////////////////////////////////////////
  // channel select and synchronizer
  ////////////////////////////////////////////////////////////////////////////
  // out of range select reads as an idle line
  assign clk_raw = (int'(i_sel) < NCH) ? i_xcom_clk[i_sel]  : 1'b0;
  assign dat_raw = (int'(i_sel) < NCH) ? i_xcom_data[i_sel] : 1'b0;

  // two flops per line, clock and data stay aligned
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      clk_s <= '0;
      dat_s <= '0;
      clk_d <= 1'b0;
    end else begin
      clk_s <= {clk_s[0], clk_raw};
      dat_s <= {dat_s[0], dat_raw};
      clk_d <= clk_s[1];
    end
  end

  assign rise = clk_s[1] & ~clk_d;

  ////////////////////////////////////////////////////////////////////////////
  // deserializer
  ////////////////////////////////////////////////////////////////////////////
  assign hdr_nxt  = {hdr_sh[xcom_pkg::HDR_W-2:0], dat_s[1]};
  assign data_nxt = {data_sh[xcom_pkg::DW-2:0], dat_s[1]};
  // length decoded as the last header bit lands
  assign n_bits   = xcom_pkg::data_bits(xcom_pkg::len_code_e'(hdr_nxt[6:5]));
  // timeout limit, 8 half periods
  assign gap_max  = {({1'b0, i_cfg_tick} + 4'd2), 3'b000};

  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      bit_cnt <= '0;
      gap_cnt <= '0;
      o_valid <= 1'b0;
      o_hdr   <= '0;
      o_data  <= '0;
    end else begin
      o_valid <= 1'b0;
      if (rise) begin
        gap_cnt <= '0;
        if (bit_cnt < 6'd8) begin
          hdr_sh  <= hdr_nxt;
          bit_cnt <= bit_cnt + 6'd1;
          if (bit_cnt == 6'd7) begin
            data_sh <= '0;
            tgt     <= 6'd8 + n_bits;
            // header only frame ends here
            if (n_bits == 6'd0) begin
              bit_cnt <= '0;
              o_valid <= 1'b1;
              o_hdr   <= hdr_nxt;
              o_data  <= '0;
            end
          end
        end else begin
          data_sh <= data_nxt;
          bit_cnt <= bit_cnt + 6'd1;
          if (bit_cnt + 6'd1 == tgt) begin
            bit_cnt <= '0;
            o_valid <= 1'b1;
            o_hdr   <= hdr_sh;
            o_data  <= data_nxt;
          end
        end
      end else if (bit_cnt != '0) begin
        // stalled frame, back to header
        if (gap_cnt == gap_max - 7'd1) begin
          bit_cnt <= '0;
          gap_cnt <= '0;
        end else begin
          gap_cnt <= gap_cnt + 7'd1;
        end
      end
    end
  end

  // board id of the last complete header
  assign o_board_id = o_hdr[3:0];

  // header plus at most 32 data bits
  a_bit_cnt_max: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    bit_cnt <= 6'd40);

endmodule

// ==== source/xcom_tx.sv ====
// serial transmitter, header MSB first then 0/8/16/32 data bits MSB first
// each half period is cfg_tick+2 clocks, data moves at the falling serial edge
// both lines sit low while idle
`timescale 1ns/1ps

module xcom_tx (
  input  logic                         i_ps_clk,
  input  logic                         i_ps_rstn,
  input  logic                         i_start,
  input  logic [xcom_pkg::HDR_W-1:0]   i_hdr,
  input  logic [xcom_pkg::DW-1:0]      i_data,
  input  logic [xcom_pkg::TICK_W-1:0]  i_cfg_tick,
  output logic                         o_busy,
  output logic                         o_xcom_clk,
  output logic                         o_xcom_data
);

  logic [5:0]                  n_bits;
  logic [xcom_pkg::TICK_W-1:0] tick_q;
  logic [xcom_pkg::TICK_W:0]   cnt;
  logic                        half_end;
  logic                        phase;
  logic [5:0]                  bits_left;
  logic [39:0]                 shreg;

  // payload length from header bits [6:5]
  assign n_bits = xcom_pkg::data_bits(xcom_pkg::len_code_e'(i_hdr[6:5]));

  // last cycle of a half period
  assign half_end = (cnt == ({1'b0, tick_q} + 1'b1));

  ////////////////////////////////////////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      o_busy    <= 1'b0;
      phase     <= 1'b0;
      cnt       <= '0;
      bits_left <= '0;
    end else if (!o_busy) begin
      if (i_start) begin
        o_busy    <= 1'b1;
        phase     <= 1'b0;
        cnt       <= '0;
        bits_left <= 6'd8 + n_bits;
      end
    end else if (half_end) begin
      cnt <= '0;
      if (!phase) begin
        // low half done, raise serial clock
        phase <= 1'b1;
      end else begin
        // high half done, move to next bit
        phase     <= 1'b0;
        bits_left <= bits_left - 6'd1;
        if (bits_left == 6'd1) begin
          o_busy <= 1'b0;
        end
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // shifter
  ////////////////////////////////////////////////////////////////////////////
  // header in [39:32], data left aligned below it so bit 39 leads
  always_ff @(posedge i_ps_clk) begin
    if (!o_busy && i_start) begin
      tick_q <= i_cfg_tick;
      shreg  <= {i_hdr, i_data << (6'd32 - n_bits)};
    end else if (o_busy && half_end && phase) begin
      shreg <= {shreg[38:0], 1'b0};
    end
  end

  assign o_xcom_clk  = phase;
  assign o_xcom_data = o_busy & shreg[39];

  // no serial clock activity outside a frame
  a_clk_idle_low: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    !o_busy |-> !o_xcom_clk);

endmodule

// ==== tb/tb_clk_gen.sv ====
// free running clock and an active low reset held for RST_CYCLES rising edges
// reset is released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 4
) (
  output logic o_clk,
  output logic o_rstn
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rstn = 1'b1;
  end

endmodule

// ==== tb/tb_xcom_link.sv ====
// loopback testbench, tx lines go to rx channel 0 and channel 1 is held low
// APB inputs move on the falling edge, outputs are sampled 2 ns later
// stops at the first mismatch
`timescale 1ns/1ps

module tb_xcom_link;

  localparam int NCH        = 2;
  localparam int SAMPLE_DLY = 2;
  // 30 frames of 40 bits at the slowest tick, plus margin
  localparam int WATCHDOG_NS = 30 * 40 * 18 * 10 + 100000;

  logic           clk;
  logic           rstn;
  logic           psel;
  logic           penable;
  logic           pwrite;
  logic [7:0]     paddr;
  logic [31:0]    pwdata;
  logic [31:0]    prdata;
  logic           pready;
  logic           pslverr;
  logic [NCH-1:0] xcom_clk_in;
  logic [NCH-1:0] xcom_data_in;
  logic           xcom_clk_out;
  logic           xcom_data_out;
  logic [3:0]     xcom_id;

  tb_clk_gen #(
    .PERIOD_NS  (10),
    .RST_CYCLES (4)
  ) u_clk_gen (
    .o_clk  (clk),
    .o_rstn (rstn)
  );

  xcom_link #(
    .NCH (NCH)
  ) u_xcom_link (
    .i_ps_clk    (clk),
    .i_ps_rstn   (rstn),
    .i_psel      (psel),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_paddr     (paddr),
    .i_pwdata    (pwdata),
    .o_prdata    (prdata),
    .o_pready    (pready),
    .o_pslverr   (pslverr),
    .i_xcom_clk  (xcom_clk_in),
    .i_xcom_data (xcom_data_in),
    .o_xcom_clk  (xcom_clk_out),
    .o_xcom_data (xcom_data_out),
    .o_xcom_id   (xcom_id)
  );

  // loopback on channel 0, channel 1 idle
  assign xcom_clk_in  = {1'b0, xcom_clk_out};
  assign xcom_data_in = {1'b0, xcom_data_out};

  ////////////////////////////////////////////////////////////////////////////
  // reference model and checker
  ////////////////////////////////////////////////////////////////////////////
  // payload masked to the length in header bits [6:5]
  function automatic logic [31:0] expected_rx(input logic [7:0] hdr, input logic [31:0] data);
    logic [31:0] res;
    case (hdr[6:5])
      2'b00:   res = 32'h0;
      2'b01:   res = {24'h0, data[7:0]};
      2'b10:   res = {16'h0, data[15:0]};
      default: res = data;
    endcase
    return res;
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, what, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB access
  ////////////////////////////////////////////////////////////////////////////
  // setup cycle, access cycle, then one idle cycle
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #SAMPLE_DLY;
    check_eq({31'h0, pready}, 32'h1, "pready on write");
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #SAMPLE_DLY;
    check_eq({31'h0, pready}, 32'h1, "pready on read");
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    logic err;
    write_reg(addr, data, err);
    check_eq({31'h0, err}, 32'h0, "pslverr on write");
  endtask

  task automatic read_ok(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    read_reg(addr, data, err);
    check_eq({31'h0, err}, 32'h0, "pslverr on read");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // frame helpers
  ////////////////////////////////////////////////////////////////////////////
  // polls STATUS until the frame count reaches target
  task automatic wait_rx_count(input logic [7:0] target);
    logic [31:0] st;
    read_ok(xcom_pkg::REG_STATUS, st);
    while (st[15:8] != target) begin
      read_ok(xcom_pkg::REG_STATUS, st);
    end
  endtask

  task automatic wait_tx_idle();
    logic [31:0] st;
    read_ok(xcom_pkg::REG_STATUS, st);
    while (st[0]) begin
      read_ok(xcom_pkg::REG_STATUS, st);
    end
  endtask

  // cfg: tick in [2:0], select in bit 8
  task automatic load_frame(input logic [2:0] tick, input logic sel,
                            input logic [7:0] hdr, input logic [31:0] data);
    write_ok(xcom_pkg::REG_CFG, {23'h0, sel, 5'h0, tick});
    write_ok(xcom_pkg::REG_TX_HDR, {24'h0, hdr});
    write_ok(xcom_pkg::REG_TX_DATA, data);
  endtask

  // one loopback frame on channel 0, checked against the reference
  task automatic run_frame(input logic [2:0] tick, input logic [7:0] hdr,
                           input logic [31:0] data);
    logic [31:0] st;
    logic [7:0]  cnt;
    load_frame(tick, 1'b0, hdr, data);
    read_ok(xcom_pkg::REG_STATUS, st);
    cnt = st[15:8];
    write_ok(xcom_pkg::REG_CTRL, 32'h1);
    wait_rx_count(cnt + 8'd1);
    read_ok(xcom_pkg::REG_RX_DATA, st);
    check_eq(st, expected_rx(hdr, data), "RX_DATA");
    read_ok(xcom_pkg::REG_STATUS, st);
    check_eq({24'h0, st[23:16]}, {24'h0, hdr}, "STATUS header");
    check_eq({28'h0, xcom_id}, {28'h0, hdr[3:0]}, "board id port");
    wait_tx_idle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [31:0] data;
    logic [7:0]  hdr;
    logic [7:0]  cnt;
    logic [2:0]  tick;
    logic        err;
    int          i;

    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 8'h0;
    pwdata  = 32'h0;
    rnd     = $urandom(13);
    @(posedge rstn);

    // reset values
    read_ok(xcom_pkg::REG_STATUS, rd);
    check_eq(rd, 32'h0, "STATUS after reset");
    read_ok(xcom_pkg::REG_RX_DATA, rd);
    check_eq(rd, 32'h0, "RX_DATA after reset");
    read_ok(xcom_pkg::REG_CFG, rd);
    check_eq(rd, 32'h0, "CFG after reset");
    check_eq({31'h0, xcom_clk_out}, 32'h0, "serial clock after reset");
    check_eq({31'h0, xcom_data_out}, 32'h0, "serial data after reset");
    check_eq({28'h0, xcom_id}, 32'h0, "board id after reset");

    // register readback
    write_ok(xcom_pkg::REG_CFG, 32'h0000_0105);
    read_ok(xcom_pkg::REG_CFG, rd);
    check_eq(rd, 32'h0000_0105, "CFG readback");
    write_ok(xcom_pkg::REG_TX_HDR, 32'h0000_00A5);
    read_ok(xcom_pkg::REG_TX_HDR, rd);
    check_eq(rd, 32'h0000_00A5, "TX_HDR readback");
    rnd = $urandom;
    write_ok(xcom_pkg::REG_TX_DATA, rnd);
    read_ok(xcom_pkg::REG_TX_DATA, rd);
    check_eq(rd, rnd, "TX_DATA readback");

    // random loopback frames, length code cycles through all four
    for (i = 0; i < 20; i++) begin
      rnd  = $urandom;
      tick = rnd[2:0];
      rnd  = $urandom;
      hdr  = {rnd[7], i[1:0], rnd[4:0]};
      data = $urandom;
      run_frame(tick, hdr, data);
    end

    // send while busy is refused, header and data writes do not touch the frame
    hdr  = 8'hE3;
    data = 32'h1234_5678;
    load_frame(3'd2, 1'b0, hdr, data);
    read_ok(xcom_pkg::REG_STATUS, rd);
    cnt = rd[15:8];
    write_ok(xcom_pkg::REG_CTRL, 32'h1);
    write_reg(xcom_pkg::REG_CTRL, 32'h1, err);
    check_eq({31'h0, err}, 32'h1, "pslverr on send while busy");
    write_ok(xcom_pkg::REG_TX_HDR, 32'h0000_002C);
    write_ok(xcom_pkg::REG_TX_DATA, 32'hDEAD_BEEF);
    wait_rx_count(cnt + 8'd1);
    read_ok(xcom_pkg::REG_RX_DATA, rd);
    check_eq(rd, expected_rx(hdr, data), "RX_DATA of frame sent during busy");
    read_ok(xcom_pkg::REG_STATUS, rd);
    check_eq({24'h0, rd[23:16]}, {24'h0, hdr}, "STATUS header of first frame");
    wait_tx_idle();
    read_ok(xcom_pkg::REG_STATUS, rd);
    check_eq({24'h0, rd[15:8]}, {24'h0, cnt + 8'd1}, "frame count after refused send");

    // unmapped offsets
    write_reg(8'h20, 32'hFFFF_FFFF, err);
    check_eq({31'h0, err}, 32'h1, "pslverr on unmapped write");
    read_reg(8'h20, rd, err);
    check_eq({31'h0, err}, 32'h1, "pslverr on unmapped read");
    check_eq(rd, 32'h0, "unmapped read data");
    read_reg(8'h03, rd, err);
    check_eq({31'h0, err}, 32'h1, "pslverr on misaligned read");

    // channel 1 sees nothing, then back to channel 0
    load_frame(3'd1, 1'b1, 8'hB5, 32'h0F0F_A5A5);
    read_ok(xcom_pkg::REG_STATUS, rd);
    cnt = rd[15:8];
    write_ok(xcom_pkg::REG_CTRL, 32'h1);
    wait_tx_idle();
    read_ok(xcom_pkg::REG_STATUS, rd);
    check_eq({24'h0, rd[15:8]}, {24'h0, cnt}, "frame count on idle channel");
    run_frame(3'd1, 8'h4A, 32'h1357_9BDF);

    $display("SIMULATION PASSED");
    $finish;
  end

  // bounds the whole run
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== xcom_link.f ====
source/xcom_pkg.sv
source/xcom_regs.sv
source/xcom_tx.sv
source/xcom_rx.sv
source/xcom_link.sv
tb/tb_clk_gen.sv
tb/tb_xcom_link.sv
